/* spi_golden.txt */
// per test, line 1: kind cfg div nbytes, then the expected rx word, byte 7 first
// line 2: nbytes tx bytes, then nbytes slave reply bytes; kind 1 over-fills the fifo
0C
00 00 01 01 00 00 00 00 00 00 00 3C
A5 3C
00 00 00 02 00 00 00 00 00 00 81 7E
12 34 81 7E
00 01 01 02 00 00 00 00 00 00 0F F0
C3 5A 0F F0
00 02 03 02 00 00 00 00 00 00 11 EE
96 69 11 EE
00 03 07 02 00 00 00 00 00 00 55 AA
01 80 55 AA
00 04 00 02 00 00 00 00 00 00 02 40
1E E1 02 40
00 05 01 02 00 00 00 00 00 00 9B B9
F5 0A 9B B9
00 06 03 02 00 00 00 00 00 00 C8 8C
37 73 C8 8C
00 07 07 01 00 00 00 00 00 00 00 01
80 01
00 00 00 0A A2 A3 A4 A5 A6 A7 A8 A9
10 11 12 13 14 15 16 17 18 19 A0 A1 A2 A3 A4 A5 A6 A7 A8 A9
00 01 03 03 00 00 00 00 00 CA FE 42
DE AD BE CA FE 42
01 00 10 14 29 2A 2B 2C 2D 2E 2F 30
00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11 12 13
20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D 2E 2F 30 31 32 33

/* files.f */
spi_pkg.sv
spi_regs.sv
spi_tx_fifo.sv
spi_clock_gen.sv
spi_master_io.sv
spi_master.sv
spi_master_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = spi_master_tb
FILELIST  = files.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJDIR)

/* spi_master_tb.sv */
`default_nettype none

// spi master testbench driven from spi_golden.txt
module spi_master_tb import spi_pkg::*; ();

   localparam int depth     = 16;  // holds a 10 byte burst
   localparam int max_bytes = 20;

   logic              clk;
   logic              nreset;
   logic              reg_write;
   spi_addr_t         reg_addr;
   logic [SPI_DW-1:0] reg_wdata;
   logic              miso;
   wire               sclk;
   wire               mosi;
   wire               ss;
   wire               rx_access;
   wire               tx_overflow;
   wire [SPI_RXW-1:0] rx_data;

   logic [7:0]  golden [0:1023];
   logic [7:0]  tx_bytes  [max_bytes];
   logic [7:0]  rep_bytes [max_bytes];
   logic [63:0] exp_word;
   logic        cur_cpol;
   logic        cur_cpha;
   logic        cur_lsb;
   int          cur_div;
   int          n_bytes;
   int          n_sent;
   int          errors;
   int          cycles;
   int          limit;

   // slave model state
   logic        prev_sclk;
   logic        prev_ss;
   logic        ss_rose;      // ss rose at the last falling edge
   logic        first_edge;
   logic        check_rest;   // sclk rest check armed
   logic [7:0]  cap_byte;
   logic [7:0]  cap_q [$];    // bytes seen on mosi
   int          drv_bit;
   int          cap_bit;
   int          half_len;
   int          ss_falls;
   int          access_count;

   spi_master #(
      .depth (depth)
   ) u_dut (
      .clk         (clk),
      .nreset      (nreset),
      .reg_write   (reg_write),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .sclk        (sclk),
      .mosi        (mosi),
      .ss          (ss),
      .miso        (miso),
      .rx_data     (rx_data),
      .rx_access   (rx_access),
      .tx_overflow (tx_overflow)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   //############################################################
   // helpers
   //############################################################
   task automatic check_equal(input logic [63:0] got, input logic [63:0] expected,
                              input string msg);
      if (got !== expected) begin
         errors++;
         $display("FAILED at %0t: %s, got %h, expected %h", $time, msg, got, expected);
      end
   endtask

   // one strobe write starting on a falling edge
   task automatic write_reg(input spi_addr_t addr, input logic [7:0] data);
      reg_write = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(negedge clk);
      reg_write = 1'b0;
   endtask

   // bit idx of the slave reply stream in wire order
   function automatic logic reply_bit(input int idx);
      logic [7:0] b;
      int         k;
      b = (idx / 8 < max_bytes) ? rep_bytes[idx / 8] : 8'h00;
      k = idx % 8;
      return cur_lsb ? b[k] : b[7 - k];
   endfunction

   //############################################################
   // spi slave model and line monitor
   //############################################################
   always @(negedge clk) begin
      logic lead;
      if (nreset) begin
         half_len++;
         if (!ss && prev_ss) begin  // frame start
            ss_falls++;
            drv_bit    = 0;
            cap_bit    = 0;
            first_edge = 1'b1;
            if (!cur_cpha) begin
               miso    = reply_bit(0);  // valid before first edge
               drv_bit = 1;
            end
         end else if (!ss && (sclk != prev_sclk)) begin
            lead = (sclk != cur_cpol);  // moved off rest level
            if (!first_edge)
               check_equal(half_len, cur_div + 1, "sclk half period");
            first_edge = 1'b0;
            half_len   = 0;
            if (lead ^ cur_cpha) begin  // sample edge
               if (cur_lsb)
                  cap_byte[cap_bit % 8] = mosi;
               else
                  cap_byte[7 - cap_bit % 8] = mosi;
               cap_bit++;
               if (cap_bit % 8 == 0)
                  cap_q.push_back(cap_byte);
            end else begin              // launch edge
               miso = reply_bit(drv_bit);
               drv_bit++;
            end
         end
         if (ss && check_rest)
            check_equal(sclk, cur_cpol, "sclk rest level");
         if (rx_access)
            access_count++;
         check_equal(rx_access, ss_rose, "rx_access one clk after ss rise");
         ss_rose   = ss & ~prev_ss;  // pulse due one clk later
         prev_sclk = sclk;
         prev_ss   = ss;
      end
   end

   // run limit
   always @(posedge clk) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("timeout: no frame completion within %0d cycles", limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   //############################################################
   // main sequence
   //############################################################
   initial begin
      int          ntests;
      int          gp;
      int          kind;
      int          cfg;
      int          gap;
      int          err_before;
      int          passed;
      logic [63:0] mask;
      void'($urandom(24956));
      nreset       = 1'b0;
      reg_write    = 1'b0;
      reg_addr     = ADDR_CFG;
      reg_wdata    = '0;
      miso         = 1'b0;
      cur_cpol     = 1'b0;
      cur_cpha     = 1'b0;
      cur_lsb      = 1'b0;
      cur_div      = 0;
      errors       = 0;
      cycles       = 0;
      limit        = 0;
      prev_sclk    = 1'b0;
      prev_ss      = 1'b1;
      ss_rose      = 1'b0;
      first_edge   = 1'b1;
      check_rest   = 1'b0;
      cap_byte     = '0;
      drv_bit      = 0;
      cap_bit      = 0;
      half_len     = 0;
      ss_falls     = 0;
      access_count = 0;
      passed       = 0;

      $readmemh("spi_golden.txt", golden);
      ntests = golden[0];
      gp     = 1;
      for (int t = 0; t < ntests; t++) begin  // frame lengths set the limit
         limit += (golden[gp + 3] * 16 + 4) * (golden[gp + 2] + 1) + 200;
         gp    += 12 + 2 * golden[gp + 3];
      end
      limit += 200;  // reset and reset-value test

      repeat (5) @(negedge clk);
      nreset = 1'b1;
      @(negedge clk);
      check_equal(ss, 1'b1, "ss after reset");
      check_equal(sclk, 1'b0, "sclk after reset");
      check_equal(mosi, 1'b0, "mosi after reset");
      check_equal(rx_access, 1'b0, "rx_access after reset");
      check_equal(tx_overflow, 1'b0, "tx_overflow after reset");
      if (errors == 0)
         passed++;
      $display("test 0 reset values: %s", (errors == 0) ? "pass" : "fail");

      gp = 1;
      for (int t = 1; t <= ntests; t++) begin
         err_before = errors;
         kind    = golden[gp];
         cfg     = golden[gp + 1];
         cur_div = golden[gp + 2];
         n_bytes = golden[gp + 3];
         for (int i = 0; i < 8; i++)
            exp_word[63 - 8 * i -: 8] = golden[gp + 4 + i];  // byte 7 first
         for (int i = 0; i < n_bytes; i++) begin
            tx_bytes[i]  = golden[gp + 12 + i];
            rep_bytes[i] = golden[gp + 12 + n_bytes + i];
         end
         gp    += 12 + 2 * n_bytes;
         n_sent = (kind == 1) ? depth + 1 : n_bytes;  // first pop plus a full fifo

         gap = $urandom % 16;  // idle gap between frames
         repeat (gap) @(negedge clk);
         check_rest   = 1'b0;
         ss_falls     = 0;
         access_count = 0;
         cap_q.delete();
         write_reg(ADDR_CFG, cfg[7:0]);
         write_reg(ADDR_DIV, cur_div[7:0]);
         cur_cpol = cfg[CFG_CPOL];
         cur_cpha = cfg[CFG_CPHA];
         cur_lsb  = cfg[CFG_LSBFIRST];
         @(negedge clk);
         check_rest = 1'b1;

         if (kind == 1) begin
            write_reg(ADDR_TX, tx_bytes[0]);
            while (ss)
               @(negedge clk);  // wait until the first byte is popped
            for (int i = 1; i < n_bytes; i++)
               write_reg(ADDR_TX, tx_bytes[i]);
            check_equal(tx_overflow, 1'b1, "overflow after over-filling the fifo");
         end else begin
            for (int i = 0; i < n_bytes; i++)
               write_reg(ADDR_TX, tx_bytes[i]);
         end

         while (!rx_access)
            @(negedge clk);
         repeat (2) @(negedge clk);  // let the monitor count the pulse

         check_equal(access_count, 1, "rx_access pulses per frame");
         check_equal(ss_falls, 1, "frames per test");
         check_equal(cap_q.size(), n_sent, "bytes seen by slave");
         for (int i = 0; i < cap_q.size() && i < n_sent; i++)
            check_equal(cap_q[i], tx_bytes[i], $sformatf("mosi byte %0d", i));
         mask = (n_sent >= 8) ? '1 : ((64'd1 << (8 * n_sent)) - 64'd1);
         check_equal(rx_data & mask, exp_word & mask, "receive word");
         if (kind == 1) begin
            write_reg(ADDR_CLR, 8'h00);
            check_equal(tx_overflow, 1'b0, "overflow after clear");
         end else begin
            check_equal(tx_overflow, 1'b0, "unexpected overflow");
         end

         if (errors == err_before)
            passed++;
         $display("test %0d cfg %0h div %0d bytes %0d: %s", t, cfg, cur_div, n_sent,
                  (errors == err_before) ? "pass" : "fail");
      end

      $display("tests %0d, passed %0d, failed %0d, failing checks %0d",
               ntests + 1, passed, ntests + 1 - passed, errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* spi_master.sv */
`default_nettype none

// spi master top
// register front end -> tx fifo -> io engine
module spi_master import spi_pkg::*; #(
   parameter int depth = 8  // tx fifo entries
) (
   input  wire                clk,
   input  wire                nreset,
   // register write bus
   input  wire                reg_write,
   input  wire spi_addr_t     reg_addr,
   input  wire [SPI_DW-1:0]   reg_wdata,
   // serial pins
   output logic               sclk,
   output logic               mosi,
   output logic               ss,
   input  wire                miso,
   // status
   output logic [SPI_RXW-1:0] rx_data,
   output logic               rx_access,
   output logic               tx_overflow
);

   logic              push;
   logic [SPI_DW-1:0] push_data;
   logic              full;
   logic              fifo_read;
   logic [SPI_DW-1:0] fifo_dout;
   logic              fifo_empty;
   logic              cpol;
   logic              cpha;
   logic              lsbfirst;
   logic [SPI_DW-1:0] clkdiv;
   logic              ss_busy;

   assign ss_busy = ~ss;  // frame running

   spi_regs u_regs (
      .clk         (clk),
      .nreset      (nreset),
      .reg_write   (reg_write),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .full        (full),
      .push        (push),
      .push_data   (push_data),
      .ss_busy     (ss_busy),
      .cpol        (cpol),
      .cpha        (cpha),
      .lsbfirst    (lsbfirst),
      .clkdiv      (clkdiv),
      .tx_overflow (tx_overflow)
   );

   spi_tx_fifo #(
      .depth (depth)
   ) u_fifo (
      .clk        (clk),
      .nreset     (nreset),
      .push       (push),
      .push_data  (push_data),
      .full       (full),
      .fifo_read  (fifo_read),
      .fifo_dout  (fifo_dout),
      .fifo_empty (fifo_empty)
   );

   spi_master_io u_io (
      .clk        (clk),
      .nreset     (nreset),
      .cpol       (cpol),
      .cpha       (cpha),
      .lsbfirst   (lsbfirst),
      .clkdiv     (clkdiv),
      .fifo_dout  (fifo_dout),
      .fifo_empty (fifo_empty),
      .fifo_read  (fifo_read),
      .rx_data    (rx_data),
      .rx_access  (rx_access),
      .sclk       (sclk),
      .mosi       (mosi),
      .ss         (ss),
      .miso       (miso),
      .spi_state  ()               // debug only
   );

endmodule

`default_nettype wire

/* spi_master_io.sv */
`default_nettype none

// spi io engine
// frame fsm, tx shifter, rx shifter, ss rise pulse
module spi_master_io import spi_pkg::*; (
   input  wire                clk,
   input  wire                nreset,
   // link config
   input  wire                cpol,
   input  wire                cpha,
   input  wire                lsbfirst,
   input  wire [SPI_DW-1:0]   clkdiv,
   // tx fifo
   input  wire [SPI_DW-1:0]   fifo_dout,
   input  wire                fifo_empty,
   output logic               fifo_read,  // one cycle pop
   // receive word
   output logic [SPI_RXW-1:0] rx_data,
   output logic               rx_access,  // frame done pulse
   // serial pins
   output logic               sclk,
   output logic               mosi,
   output logic               ss,
   input  wire                miso,
   output spi_state_t         spi_state
);

   logic              edge_tick;  // half period strobe
   logic              phase;      // sclk toggle phase
   logic              run;
   logic [3:0]        half_cnt;   // half periods done in this byte
   logic              boundary;   // next byte may start here
   logic              byte_end;   // last tick of a byte
   logic              leading;    // next tick is first edge of a bit
   logic              tx_shift;
   logic              rx_sample;
   logic              rx_first;   // first bit of a byte
   logic              load_byte;  // shifter load, cycle after pop
   logic [SPI_DW-1:0] tx_sr;
   logic              ss_q;

   //############################################################
   // clock generator
   //############################################################
   assign run = (spi_state == SPI_DATA);  // sclk only moves in data

   spi_clock_gen u_clock_gen (
      .clk       (clk),
      .nreset    (nreset),
      .clkdiv    (clkdiv),
      .run       (run),
      .edge_tick (edge_tick),
      .phase     (phase)
   );

   assign sclk = cpol ^ phase;  // phase is 0 outside data

   //############################################################
   // frame state machine
   //############################################################
   assign byte_end = edge_tick & run & (half_cnt == 4'd15);
   assign boundary = (spi_state == SPI_IDLE) | (run & (half_cnt == 4'd15));

   // pop one boundary ahead of the byte it feeds
   assign fifo_read = edge_tick & boundary & ~fifo_empty;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         spi_state <= SPI_IDLE;
      end else begin
         case (spi_state)
            SPI_IDLE: begin
               if (fifo_read)
                  spi_state <= SPI_SETUP;  // ss falls here
            end
            SPI_SETUP: begin
               if (edge_tick)
                  spi_state <= SPI_DATA;
            end
            SPI_DATA: begin
               if (byte_end && fifo_empty)
                  spi_state <= SPI_HOLD;   // nothing queued, close frame
            end
            SPI_HOLD: begin
               if (edge_tick)
                  spi_state <= SPI_IDLE;
            end
            default: spi_state <= SPI_IDLE;
         endcase
      end
   end

   // 16 half periods per byte, wraps into the next byte
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         half_cnt <= '0;
      else if (!run)
         half_cnt <= '0;
      else if (edge_tick)
         half_cnt <= half_cnt + 1'b1;
   end

   //############################################################
   // edge selection
   //############################################################
   assign leading  = ~half_cnt[0];            // ticks 1,3,..,15
   assign rx_first = (half_cnt[3:1] == 3'd0);

   // cpha 0: shift on trailing, sample on leading
   // cpha 1: shift on leading, sample on trailing
   assign tx_shift  = edge_tick & run &
                      (cpha ? (leading & (half_cnt != 4'd0))
                            : (~leading & (half_cnt != 4'd15)));
   assign rx_sample = edge_tick & run & (cpha ? ~leading : leading);

   //############################################################
   // tx shifter
   //############################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         load_byte <= 1'b0;
      else
         load_byte <= fifo_read;
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         tx_sr <= '0;
      else if (load_byte)
         tx_sr <= fifo_dout;  // popped byte still at fifo head
      else if (tx_shift)
         tx_sr <= lsbfirst ? {1'b0, tx_sr[SPI_DW-1:1]}
                           : {tx_sr[SPI_DW-2:0], 1'b0};
   end

   assign mosi = lsbfirst ? tx_sr[0] : tx_sr[SPI_DW-1];

   //############################################################
   // rx shifter
   //############################################################
   // newest byte always in 7:0, lsbfirst only reverses bits in a byte
   always_ff @(posedge clk) begin
      if (rx_sample) begin
         if (!lsbfirst)
            rx_data <= {rx_data[SPI_RXW-2:0], miso};
         else if (rx_first)
            rx_data <= {rx_data[SPI_RXW-SPI_DW-1:0], miso, {(SPI_DW-1){1'b0}}};
         else
            rx_data[SPI_DW-1:0] <= {miso, rx_data[SPI_DW-1:1]};
      end
   end

   //############################################################
   // slave select and done pulse
   //############################################################
   assign ss = (spi_state == SPI_IDLE);

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         ss_q      <= 1'b1;
         rx_access <= 1'b0;
      end else begin
         ss_q      <= ss;
         rx_access <= ss & ~ss_q;  // one clk after the rise
      end
   end

   a_sclk_rest : assert property (
      @(posedge clk) disable iff (!nreset)
      ss |-> (sclk == cpol)
   ) else $error("sclk off its rest level while ss high");

endmodule

`default_nettype wire

/* spi_clock_gen.sv */
`default_nettype none

// sclk divider
// free running half period counter plus the sclk toggle phase
module spi_clock_gen import spi_pkg::*; (
   input  wire              clk,
   input  wire              nreset,
   input  wire [SPI_DW-1:0] clkdiv,     // half period = clkdiv+1
   input  wire              run,        // engine in data state
   output logic             edge_tick,  // one cycle per half period
   output logic             phase       // 0 = idle level
);

   logic [SPI_DW-1:0] cnt;  // half period counter

   //############################################################
   // half period counter
   //############################################################
   // >= so a divider lowered mid count still wraps at once
   assign edge_tick = (cnt >= clkdiv);

   // never stops, idle frames start on a tick as well
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         cnt <= '0;
      else if (edge_tick)
         cnt <= '0;
      else
         cnt <= cnt + 1'b1;
   end

   //############################################################
   // toggle phase
   //############################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         phase <= 1'b0;
      else if (!run)
         phase <= 1'b0;       // back to rest level
      else if (edge_tick)
         phase <= ~phase;     // one sclk edge per tick
   end

endmodule

`default_nettype wire

/* spi_tx_fifo.sv */
`default_nettype none

// transmit fifo
// circular buffer, pointers carry a wrap bit, registered head byte
module spi_tx_fifo import spi_pkg::*; #(
   parameter int depth = 8  // power of two, 2 or more
) (
   input  wire               clk,
   input  wire               nreset,
   // write side
   input  wire               push,
   input  wire [SPI_DW-1:0]  push_data,
   output logic              full,
   // read side
   input  wire               fifo_read,
   output logic [SPI_DW-1:0] fifo_dout,   // head byte
   output logic              fifo_empty
);

   localparam int aw = $clog2(depth);  // index bits

   logic [SPI_DW-1:0] mem [depth];
   logic [aw:0]       wr_ptr;  // msb is wrap bit
   logic [aw:0]       rd_ptr;

   //############################################################
   // pointers
   //############################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (fifo_read)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // same index, wrap bits differ -> full
   assign fifo_empty = (wr_ptr == rd_ptr);
   assign full       = (wr_ptr[aw] != rd_ptr[aw]) &&
                       (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

   //############################################################
   // storage
   //############################################################
   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr[aw-1:0]] <= push_data;
   end

   // head register follows the read pointer one cycle late
   // so the popped byte is still here the cycle after fifo_read
   always_ff @(posedge clk) begin
      if (push && (wr_ptr == rd_ptr))
         fifo_dout <= push_data;  // bypass, slot written this edge
      else
         fifo_dout <= mem[rd_ptr[aw-1:0]];
   end

   //############################################################
   // checks
   //############################################################
   a_no_underflow : assert property (
      @(posedge clk) disable iff (!nreset)
      fifo_read |-> !fifo_empty
   ) else $error("fifo pop while empty");

   a_no_overflow : assert property (
      @(posedge clk) disable iff (!nreset)
      push |-> !full
   ) else $error("fifo push while full");

endmodule

`default_nettype wire

/* spi_regs.sv */
`default_nettype none

// register front end
// decodes strobe writes into config, fifo pushes and overflow clear
module spi_regs import spi_pkg::*; (
   input  wire              clk,
   input  wire              nreset,
   // write strobe bus
   input  wire              reg_write,   // one cycle
   input  wire spi_addr_t   reg_addr,
   input  wire [SPI_DW-1:0] reg_wdata,
   // fifo side
   input  wire              full,        // level from fifo
   output logic             push,        // one cycle
   output logic [SPI_DW-1:0] push_data,
   // engine side
   input  wire              ss_busy,     // frame in progress
   output logic             cpol,
   output logic             cpha,
   output logic             lsbfirst,
   output logic [SPI_DW-1:0] clkdiv,
   output logic             tx_overflow  // sticky
);

   logic wr_tx;    // write to tx address
   logic wr_cfg;   // any config write

   //############################################################
   // decode
   //############################################################
   assign wr_tx  = reg_write & (reg_addr == ADDR_TX);
   assign wr_cfg = reg_write & ((reg_addr == ADDR_CFG) | (reg_addr == ADDR_DIV));

   // push goes straight to the fifo on the same edge
   assign push      = wr_tx & ~full;  // dropped when full
   assign push_data = reg_wdata;

   //############################################################
   // config and overflow registers
   //############################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cpol        <= 1'b0;
         cpha        <= 1'b0;
         lsbfirst    <= 1'b0;
         clkdiv      <= '0;
         tx_overflow <= 1'b0;
      end else if (reg_write) begin
         case (reg_addr)
            ADDR_CFG: begin
               cpol     <= reg_wdata[CFG_CPOL];
               cpha     <= reg_wdata[CFG_CPHA];
               lsbfirst <= reg_wdata[CFG_LSBFIRST];
            end
            ADDR_DIV: clkdiv <= reg_wdata;  // half period = clkdiv+1
            ADDR_TX: begin
               if (full)
                  tx_overflow <= 1'b1;  // lost byte, flag until cleared
            end
            ADDR_CLR: tx_overflow <= 1'b0;
            default: ;
         endcase
      end
   end

   // link settings must be stable for a whole frame
   a_cfg_idle : assert property (
      @(posedge clk) disable iff (!nreset)
      wr_cfg |-> !ss_busy
   ) else $error("config write while ss low");

endmodule

`default_nettype wire

/* spi_pkg.sv */
`default_nettype none

//############################################################
// shared widths and encodings for the spi master
//############################################################

package spi_pkg;

   // datapath widths
   localparam int SPI_DW  = 8;   // one serial byte
   localparam int SPI_RXW = 64;  // receive word, last 8 bytes

   //############################################################
   // frame state machine
   //############################################################
   typedef enum logic [1:0] {
      SPI_IDLE  = 2'b00,  // ss high, waiting for data
      SPI_SETUP = 2'b01,  // ss low, one half period before sclk
      SPI_DATA  = 2'b10,  // 16 half periods per byte
      SPI_HOLD  = 2'b11   // ss low, one half period after sclk
   } spi_state_t;

   //############################################################
   // register map
   //############################################################
   // cfg bit 0 cpol, bit 1 cpha, bit 2 lsbfirst
   typedef enum logic [1:0] {
      ADDR_CFG = 2'd0,  // link configuration
      ADDR_DIV = 2'd1,  // sclk divider
      ADDR_TX  = 2'd2,  // push tx byte
      ADDR_CLR = 2'd3   // clear sticky overflow
   } spi_addr_t;

   // cfg field positions
   localparam int CFG_CPOL     = 0;
   localparam int CFG_CPHA     = 1;
   localparam int CFG_LSBFIRST = 2;

endpackage

`default_nettype wire
